//--- files.f
hw/sudoku_pkg.sv
hw/button_sync.sv
hw/game_fsm.sv
hw/board_store.sv
hw/solution_checker.sv
hw/sudoku_top.sv
verification/sudoku_assert.sv
verification/sudoku_tb.sv

//--- run.sh
#!/bin/sh
# build the sudoku testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sudoku_tb -f files.f -Mdir obj_dir -o sudoku_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sudoku_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log_file"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi

//--- verification/sudoku_tb.sv
`timescale 1ns/1ps

module sudoku_tb;

  localparam int press_cycles = 10;
  localparam int move_worst = 8 * press_cycles;
  localparam int edit_worst = move_worst + 8 * press_cycles;
  localparam int load_worst = 2 * press_cycles + 90;
  localparam int scan_worst = 2 * 81 + 20;
  // worst case of the five tests in clock cycles
  localparam int tests_worst = (4 + 4 * press_cycles) + (load_worst + 85 * move_worst)
    + (6 * edit_worst) + (4 + load_worst + 41 * edit_worst + 2 * scan_worst)
    + (load_worst + 82 * move_worst);
  localparam int watchdog_ns = 2 * tests_worst * 10;

  localparam sudoku_pkg::buttons_t btn_start = 7'b1000000;
  localparam sudoku_pkg::buttons_t btn_a     = 7'b0100000;
  localparam sudoku_pkg::buttons_t btn_b     = 7'b0010000;
  localparam sudoku_pkg::buttons_t btn_up    = 7'b0001000;
  localparam sudoku_pkg::buttons_t btn_down  = 7'b0000100;
  localparam sudoku_pkg::buttons_t btn_left  = 7'b0000010;
  localparam sudoku_pkg::buttons_t btn_right = 7'b0000001;

  logic                    clk = 1'b0;
  logic                    reset;
  sudoku_pkg::buttons_t    buttons;
  sudoku_pkg::game_state_t state;
  sudoku_pkg::difficulty_t difficulty;
  sudoku_pkg::cursor_t     cursor;
  logic [3:0]              edit_digit;
  logic [3:0]              cursor_cell;
  logic                    cursor_given;
  logic                    solved;
  logic [15:0]             lfsr_state;

  always #5 clk = ~clk;

  sudoku_top #(.SYNC_STAGES(2)) DUT (
    .clk         (clk),
    .reset       (reset),
    .buttons     (buttons),
    .state       (state),
    .difficulty  (difficulty),
    .cursor      (cursor),
    .edit_digit  (edit_digit),
    .cursor_cell (cursor_cell),
    .cursor_given(cursor_given),
    .solved      (solved)
  );

  function automatic int expected_digit(int row, int col);
    return (row * 3 + row / 3 + col) % 9 + 1;
  endfunction

  function automatic int expect_blank(sudoku_pkg::difficulty_t diff, int row, int col);
    if (diff == sudoku_pkg::diff_easy) begin
      return ((row * 9 + col) % 3) == 0;
    end
    return ((row + col) % 2) == 1;
  endfunction

  // fibonacci lfsr with taps 16 14 13 11
  function automatic int lfsr_bits(int count);
    int   value;
    logic fb;
    value = 0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value = (value << 1) | int'(fb);
    end
    return value;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string test_name, int expected, int actual);
    if (expected != actual) begin
      abort_run($sformatf("FAILED %s expected %0d actual %0d", test_name, expected, actual));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset   <= 1'b1;
    buttons <= '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  // hold long enough for the synchroniser and then let the level fall again
  task automatic press_button(sudoku_pkg::buttons_t mask);
    @(posedge clk);
    buttons <= mask;
    repeat (3) @(posedge clk);
    buttons <= '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_state(sudoku_pkg::game_state_t target, int max_cycles);
    int count;
    count = 0;
    @(negedge clk);
    while (state != target && count < max_cycles) begin
      @(negedge clk);
      count++;
    end
    if (state != target) begin
      abort_run($sformatf("timed out after %0d cycles waiting for state %s",
        max_cycles, target.name()));
    end
  endtask

  // cursor packs col above row
  task automatic move_cursor_to(int row, int col, string test_name);
    sudoku_pkg::buttons_t mask;
    for (int step = 0; step < 9; step++) begin
      @(negedge clk);
      mask       = '0;
      mask.up    = int'(cursor.row) > row;
      mask.down  = int'(cursor.row) < row;
      mask.left  = int'(cursor.col) > col;
      mask.right = int'(cursor.col) < col;
      if (mask == '0) begin
        break;
      end
      press_button(mask);
    end
    check_value({test_name, " cursor"}, col * 16 + row, int'(cursor));
  endtask

  task automatic read_cell(int row, int col, string test_name, output int value,
                           output int given);
    move_cursor_to(row, col, test_name);
    @(negedge clk);
    value = int'(cursor_cell);
    given = int'(cursor_given);
  endtask

  task automatic write_digit(int row, int col, int digit, string test_name);
    move_cursor_to(row, col, test_name);
    press_button(btn_a);
    check_value({test_name, " enter edit"}, sudoku_pkg::st_edit, int'(state));
    if (digit <= 5) begin
      repeat (digit) press_button(btn_up);
    end else begin
      repeat (10 - digit) press_button(btn_down);
    end
    check_value({test_name, " edit digit"}, digit, int'(edit_digit));
    press_button(btn_a);
    check_value({test_name, " back to browse"}, sudoku_pkg::st_browse, int'(state));
  endtask

  task automatic load_board(sudoku_pkg::difficulty_t diff, string test_name);
    press_button(diff == sudoku_pkg::diff_easy ? btn_up : btn_down);
    press_button(btn_a);
    check_value({test_name, " loading"}, sudoku_pkg::st_loading, int'(state));
    wait_state(sudoku_pkg::st_browse, load_worst);
    check_value({test_name, " difficulty"}, diff, int'(difficulty));
    check_value({test_name, " solved"}, 0, int'(solved));
  endtask

  task automatic check_board(sudoku_pkg::difficulty_t diff, int blank_total, string test_name);
    int value;
    int given;
    int blank;
    int blanks;
    int col;
    blanks = 0;
    for (int row = 0; row < 9; row++) begin
      for (int step = 0; step < 9; step++) begin
        // serpentine walk with one press per cell
        col = (row % 2 == 0) ? step : 8 - step;
        read_cell(row, col, test_name, value, given);
        blank = expect_blank(diff, row, col);
        blanks += (given == 0);
        check_value($sformatf("%s value %0d,%0d", test_name, row, col),
          blank ? 0 : expected_digit(row, col), value);
        check_value($sformatf("%s given %0d,%0d", test_name, row, col), blank ? 0 : 1, given);
      end
    end
    check_value({test_name, " blank count"}, blank_total, blanks);
  endtask

  task automatic test_menu_flow();
    apply_reset();
    check_value("menu reset state", sudoku_pkg::st_title, int'(state));
    check_value("menu reset cursor", 4 * 16 + 4, int'(cursor));
    check_value("menu reset solved", 0, int'(solved));
    check_value("menu reset digit", 0, int'(edit_digit));
    press_button(btn_start);
    check_value("menu start", sudoku_pkg::st_select_difficulty, int'(state));
    press_button(btn_down);
    check_value("menu down", sudoku_pkg::diff_hard, int'(difficulty));
    press_button(btn_up);
    check_value("menu up", sudoku_pkg::diff_easy, int'(difficulty));
  endtask

  task automatic test_easy_load();
    load_board(sudoku_pkg::diff_easy, "easy load");
    check_board(sudoku_pkg::diff_easy, 27, "easy board");
    move_cursor_to(0, 0, "edge top left");
    press_button(sudoku_pkg::buttons_t'(btn_up | btn_left));
    check_value("edge top left", 0, int'(cursor));
    move_cursor_to(8, 8, "edge bottom right");
    press_button(sudoku_pkg::buttons_t'(btn_down | btn_right));
    check_value("edge bottom right", 8 * 16 + 8, int'(cursor));
  endtask

  task automatic test_editing();
    int value;
    int given;
    move_cursor_to(0, 0, "edit wrap");
    press_button(btn_a);
    check_value("edit entry digit", 0, int'(edit_digit));
    press_button(btn_down);
    check_value("edit wrap down", 9, int'(edit_digit));
    press_button(btn_up);
    check_value("edit wrap up", 0, int'(edit_digit));
    repeat (5) press_button(btn_up);
    press_button(btn_b);
    check_value("edit cancel state", sudoku_pkg::st_browse, int'(state));
    read_cell(0, 0, "edit cancel", value, given);
    check_value("edit cancel value", 0, value);
    write_digit(0, 0, 3, "edit write");
    read_cell(0, 0, "edit write", value, given);
    check_value("edit write value", 3, value);
    write_digit(0, 1, 7, "edit given");
    read_cell(0, 1, "edit given", value, given);
    check_value("edit given value", expected_digit(0, 1), value);
    check_value("edit given flag", 1, given);
    move_cursor_to(0, 0, "browse clear");
    press_button(btn_b);
    read_cell(0, 0, "browse clear", value, given);
    check_value("browse clear value", 0, value);
  endtask

  task automatic test_solve_victory();
    int row_q[$];
    int col_q[$];
    int pick;
    int wrong_row;
    int wrong_col;
    int value;
    int given;
    int blanks;
    blanks = 0;
    apply_reset();
    press_button(btn_start);
    load_board(sudoku_pkg::diff_hard, "solve load");
    for (int row = 0; row < 9; row++) begin
      for (int col = 0; col < 9; col++) begin
        if (expect_blank(sudoku_pkg::diff_hard, row, col) != 0) begin
          row_q.push_back(row);
          col_q.push_back(col);
        end
      end
    end
    // the first cell drawn gets a digit offset by 1 to 8
    pick      = lfsr_bits(6) % row_q.size();
    wrong_row = row_q[pick];
    wrong_col = col_q[pick];
    read_cell(wrong_row, wrong_col, "solve wrong", value, given);
    blanks += (given == 0 && value == 0);
    write_digit(wrong_row, wrong_col,
      (expected_digit(wrong_row, wrong_col) + lfsr_bits(3)) % 9 + 1, "solve wrong");
    row_q.delete(pick);
    col_q.delete(pick);
    while (row_q.size() > 0) begin
      pick = lfsr_bits(6) % row_q.size();
      read_cell(row_q[pick], col_q[pick], "solve fill", value, given);
      blanks += (given == 0 && value == 0);
      write_digit(row_q[pick], col_q[pick], expected_digit(row_q[pick], col_q[pick]),
        "solve fill");
      row_q.delete(pick);
      col_q.delete(pick);
    end
    check_value("solve blank count", 40, blanks);
    repeat (scan_worst) @(negedge clk);
    check_value("solve wrong solved", 0, int'(solved));
    check_value("solve wrong state", sudoku_pkg::st_browse, int'(state));
    write_digit(wrong_row, wrong_col, expected_digit(wrong_row, wrong_col), "solve fix");
    wait_state(sudoku_pkg::st_victory, scan_worst);
    check_value("solve victory solved", 1, int'(solved));
  endtask

  task automatic test_restart();
    press_button(btn_start);
    check_value("restart state", sudoku_pkg::st_select_difficulty, int'(state));
    check_value("restart cursor", 4 * 16 + 4, int'(cursor));
    load_board(sudoku_pkg::diff_easy, "restart load");
    check_board(sudoku_pkg::diff_easy, 27, "restart board");
  endtask

  initial begin
    reset      = 1'b1;
    buttons    = '0;
    lfsr_state = 16'(87636);
    test_menu_flow();
    test_easy_load();
    test_editing();
    test_solve_victory();
    test_restart();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    abort_run("timeout: the tests did not finish within the watchdog limit");
  end

endmodule

//--- verification/sudoku_assert.sv
`timescale 1ns/1ps

module sudoku_assert (
  input logic                    clk,
  input logic                    reset,
  input logic                    load_start,
  input logic                    load_done,
  input sudoku_pkg::game_state_t state,
  input sudoku_pkg::cursor_t     cursor,
  input sudoku_pkg::cell_write_t cell_write
);

  // store fills 81 cells before answering
  load_latency: assert property (@(posedge clk) disable iff (reset)
    load_start |-> ##81 load_done)
    else $error("load_done did not follow load_start after 81 cycles");

  cursor_range: assert property (@(posedge clk) disable iff (reset)
    cursor.row <= sudoku_pkg::GRID_MAX && cursor.col <= sudoku_pkg::GRID_MAX)
    else $error("cursor left the board");

  write_state: assert property (@(posedge clk) disable iff (reset)
    cell_write.valid |-> (state == sudoku_pkg::st_browse || state == sudoku_pkg::st_edit))
    else $error("cell write outside browse or edit");

  legal_state: assert property (@(posedge clk) disable iff (reset)
    state inside {sudoku_pkg::st_title, sudoku_pkg::st_select_difficulty,
                  sudoku_pkg::st_loading, sudoku_pkg::st_browse,
                  sudoku_pkg::st_edit, sudoku_pkg::st_victory})
    else $error("game state left its enum range");

endmodule

// the fsm sees both ends of the load handshake
bind game_fsm sudoku_assert fsm_checks (
  .clk       (clk),
  .reset     (reset),
  .load_start(load_start),
  .load_done (load_done),
  .state     (state),
  .cursor    (cursor),
  .cell_write(cell_write)
);

//--- hw/sudoku_top.sv
`timescale 1ns/1ps

module sudoku_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  sudoku_pkg::buttons_t    buttons,
  output sudoku_pkg::game_state_t state,
  output sudoku_pkg::difficulty_t difficulty,
  output sudoku_pkg::cursor_t     cursor,
  output logic [3:0]              edit_digit,
  output logic [3:0]              cursor_cell,
  output logic                    cursor_given,
  output logic                    solved
);

  sudoku_pkg::buttons_t    presses;
  sudoku_pkg::cell_write_t cell_write;
  sudoku_pkg::cell_index_t scan_index;
  logic                    load_start;
  logic                    load_done;
  logic                    board_changed;
  logic [3:0]              scan_value;

  button_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_button_sync (
    .clk    (clk),
    .reset  (reset),
    .raw    (buttons),
    .presses(presses)
  );

  game_fsm u_game_fsm (
    .clk       (clk),
    .reset     (reset),
    .presses   (presses),
    .load_done (load_done),
    .solved    (solved),
    .state     (state),
    .difficulty(difficulty),
    .cursor    (cursor),
    .edit_digit(edit_digit),
    .load_start(load_start),
    .cell_write(cell_write)
  );

  board_store u_board_store (
    .clk          (clk),
    .reset        (reset),
    .load_start   (load_start),
    .difficulty   (difficulty),
    .cell_write   (cell_write),
    .cursor       (cursor),
    .scan_index   (scan_index),
    .load_done    (load_done),
    .board_changed(board_changed),
    .cursor_cell  (cursor_cell),
    .cursor_given (cursor_given),
    .scan_value   (scan_value)
  );

  solution_checker u_solution_checker (
    .clk          (clk),
    .reset        (reset),
    .board_changed(board_changed),
    .scan_value   (scan_value),
    .scan_index   (scan_index),
    .solved       (solved)
  );

endmodule

//--- hw/solution_checker.sv
`timescale 1ns/1ps

module solution_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    board_changed,
  input  logic [3:0]              scan_value,
  output sudoku_pkg::cell_index_t scan_index,
  output logic                    solved
);

  // row and col follow scan_index
  logic [3:0] scan_row;
  logic [3:0] scan_col;
  logic       all_match;
  logic       cell_match;

  assign cell_match = (scan_value == sudoku_pkg::solution_digit(scan_row, scan_col));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scan_index <= '0;
      scan_row   <= 4'd0;
      scan_col   <= 4'd0;
      all_match  <= 1'b1;
      solved     <= 1'b0;
    end else if (board_changed) begin
      // any change voids the running pass
      scan_index <= '0;
      scan_row   <= 4'd0;
      scan_col   <= 4'd0;
      all_match  <= 1'b1;
      solved     <= 1'b0;
    end else if (scan_index == sudoku_pkg::LAST_INDEX) begin
      // end of pass, keep scanning from the top
      solved     <= all_match && cell_match;
      scan_index <= '0;
      scan_row   <= 4'd0;
      scan_col   <= 4'd0;
      all_match  <= 1'b1;
    end else begin
      all_match  <= all_match && cell_match;
      scan_index <= scan_index + 7'd1;
      if (scan_col == sudoku_pkg::GRID_MAX) begin
        scan_col <= 4'd0;
        scan_row <= scan_row + 4'd1;
      end else begin
        scan_col <= scan_col + 4'd1;
      end
    end
  end

endmodule

//--- hw/board_store.sv
`timescale 1ns/1ps

module board_store (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load_start,
  input  sudoku_pkg::difficulty_t difficulty,
  input  sudoku_pkg::cell_write_t cell_write,
  input  sudoku_pkg::cursor_t     cursor,
  input  sudoku_pkg::cell_index_t scan_index,
  output logic                    load_done,
  output logic                    board_changed,
  output logic [3:0]              cursor_cell,
  output logic                    cursor_given,
  output logic [3:0]              scan_value
);

  logic [3:0] cell_value [sudoku_pkg::NUM_CELLS];
  logic       cell_given [sudoku_pkg::NUM_CELLS];

  // loader walks the board in index order
  logic                    loading;
  sudoku_pkg::difficulty_t load_diff;
  sudoku_pkg::cell_index_t load_index;
  logic [3:0]              load_row;
  logic [3:0]              load_col;
  logic                    load_blank;

  sudoku_pkg::cell_index_t write_index;
  sudoku_pkg::cell_index_t cursor_index;
  logic                    write_applied;

  assign write_index  = sudoku_pkg::cell_index(cell_write.pos.row, cell_write.pos.col);
  assign cursor_index = sudoku_pkg::cell_index(cursor.row, cursor.col);
  assign load_blank   = sudoku_pkg::is_blank(load_diff, load_row, load_col);

  // given cells are locked, and writes wait out a load
  assign write_applied = cell_write.valid && !loading && !cell_given[write_index];

  assign load_done     = loading && (load_index == sudoku_pkg::LAST_INDEX);
  assign board_changed = loading || write_applied;

  assign cursor_cell  = cell_value[cursor_index];
  assign cursor_given = cell_given[cursor_index];
  assign scan_value   = cell_value[scan_index];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      loading    <= 1'b0;
      load_diff  <= sudoku_pkg::diff_easy;
      load_index <= '0;
      load_row   <= 4'd0;
      load_col   <= 4'd0;
    end else if (load_start) begin
      loading    <= 1'b1;
      load_diff  <= difficulty;
      load_index <= '0;
      load_row   <= 4'd0;
      load_col   <= 4'd0;
    end else if (loading) begin
      if (load_index == sudoku_pkg::LAST_INDEX) begin
        loading <= 1'b0;
      end
      load_index <= load_index + 7'd1;
      if (load_col == sudoku_pkg::GRID_MAX) begin
        load_col <= 4'd0;
        load_row <= load_row + 4'd1;
      end else begin
        load_col <= load_col + 4'd1;
      end
    end
  end

  // board contents start empty with nothing given
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < sudoku_pkg::NUM_CELLS; i++) begin
        cell_value[i] <= 4'd0;
        cell_given[i] <= 1'b0;
      end
    end else if (loading) begin
      cell_value[load_index] <= load_blank ? 4'd0 : sudoku_pkg::solution_digit(load_row, load_col);
      cell_given[load_index] <= !load_blank;
    end else if (write_applied) begin
      cell_value[write_index] <= cell_write.value;
    end
  end

endmodule

//--- hw/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  sudoku_pkg::buttons_t    presses,
  input  logic                    load_done,
  input  logic                    solved,
  output sudoku_pkg::game_state_t state,
  output sudoku_pkg::difficulty_t difficulty,
  output sudoku_pkg::cursor_t     cursor,
  output logic [3:0]              edit_digit,
  output logic                    load_start,
  output sudoku_pkg::cell_write_t cell_write
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= sudoku_pkg::st_title;
      difficulty <= sudoku_pkg::diff_easy;
      cursor.row <= sudoku_pkg::CURSOR_HOME;
      cursor.col <= sudoku_pkg::CURSOR_HOME;
      edit_digit <= 4'd0;
      load_start <= 1'b0;
      cell_write <= '0;
    end else begin
      // strobes last a single cycle
      load_start       <= 1'b0;
      cell_write.valid <= 1'b0;

      case (state)
        sudoku_pkg::st_title: begin
          if (presses.start) begin
            state <= sudoku_pkg::st_select_difficulty;
          end
        end

        sudoku_pkg::st_select_difficulty: begin
          if (presses.up) begin
            difficulty <= sudoku_pkg::diff_easy;
          end else if (presses.down) begin
            difficulty <= sudoku_pkg::diff_hard;
          end
          if (presses.a) begin
            load_start <= 1'b1;
            state      <= sudoku_pkg::st_loading;
          end
        end

        // presses are dropped while the store fills
        sudoku_pkg::st_loading: begin
          if (load_done) begin
            state <= sudoku_pkg::st_browse;
          end
        end

        sudoku_pkg::st_browse: begin
          if (solved) begin
            state <= sudoku_pkg::st_victory;
          end else if (presses.a) begin
            edit_digit <= 4'd0;
            state      <= sudoku_pkg::st_edit;
          end else if (presses.b) begin
            // clear the cell under the cursor
            cell_write.valid <= 1'b1;
            cell_write.pos   <= cursor;
            cell_write.value <= 4'd0;
          end else begin
            // arrows saturate at the board edges
            if (presses.up && cursor.row != 4'd0) begin
              cursor.row <= cursor.row - 4'd1;
            end else if (presses.down && cursor.row != sudoku_pkg::GRID_MAX) begin
              cursor.row <= cursor.row + 4'd1;
            end
            if (presses.left && cursor.col != 4'd0) begin
              cursor.col <= cursor.col - 4'd1;
            end else if (presses.right && cursor.col != sudoku_pkg::GRID_MAX) begin
              cursor.col <= cursor.col + 4'd1;
            end
          end
        end

        sudoku_pkg::st_edit: begin
          if (solved) begin
            state <= sudoku_pkg::st_victory;
          end else if (presses.a) begin
            cell_write.valid <= 1'b1;
            cell_write.pos   <= cursor;
            cell_write.value <= edit_digit;
            state            <= sudoku_pkg::st_browse;
          end else if (presses.b) begin
            state <= sudoku_pkg::st_browse;
          end else if (presses.up) begin
            // 0..9 with wraparound
            if (edit_digit == sudoku_pkg::DIGIT_MAX) begin
              edit_digit <= 4'd0;
            end else begin
              edit_digit <= edit_digit + 4'd1;
            end
          end else if (presses.down) begin
            if (edit_digit == 4'd0) begin
              edit_digit <= sudoku_pkg::DIGIT_MAX;
            end else begin
              edit_digit <= edit_digit - 4'd1;
            end
          end
        end

        sudoku_pkg::st_victory: begin
          if (presses.start) begin
            cursor.row <= sudoku_pkg::CURSOR_HOME;
            cursor.col <= sudoku_pkg::CURSOR_HOME;
            state      <= sudoku_pkg::st_select_difficulty;
          end
        end

        default: begin
          state <= sudoku_pkg::st_title;
        end
      endcase
    end
  end

endmodule

//--- hw/button_sync.sv
`timescale 1ns/1ps

module button_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                 clk,
  input  logic                 reset,
  input  sudoku_pkg::buttons_t raw,
  output sudoku_pkg::buttons_t presses
);

  // stage 0 samples the raw pins
  sudoku_pkg::buttons_t [SYNC_STAGES-1:0] sync_chain;
  sudoku_pkg::buttons_t                   level_prev;
  sudoku_pkg::buttons_t                   level;

  assign level = sync_chain[SYNC_STAGES-1];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_chain <= '0;
    end else begin
      sync_chain[0] <= raw;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_chain[i] <= sync_chain[i-1];
      end
    end
  end

  // rising edge of the synchronised level, registered
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      level_prev <= '0;
      presses    <= '0;
    end else begin
      level_prev <= level;
      presses    <= level & ~level_prev;
    end
  end

endmodule

//--- hw/sudoku_pkg.sv
package sudoku_pkg;

  // board geometry
  localparam int NUM_CELLS = 81;
  localparam logic [6:0] LAST_INDEX = 7'd80;
  localparam logic [3:0] GRID_MAX = 4'd8;
  localparam logic [3:0] CURSOR_HOME = 4'd4;
  localparam logic [3:0] DIGIT_MAX = 4'd9;

  typedef enum logic [2:0] {
    st_title,
    st_select_difficulty,
    st_loading,
    st_browse,
    st_edit,
    st_victory
  } game_state_t;

  typedef enum logic {
    diff_easy,
    diff_hard
  } difficulty_t;

  typedef struct packed {
    logic start;
    logic a;
    logic b;
    logic up;
    logic down;
    logic left;
    logic right;
  } buttons_t;

  typedef struct packed {
    logic [3:0] col;
    logic [3:0] row;
  } cursor_t;

  // value 0 means an empty cell
  typedef struct packed {
    logic       valid;
    cursor_t    pos;
    logic [3:0] value;
  } cell_write_t;

  typedef logic [6:0] cell_index_t;

  function automatic cell_index_t cell_index(logic [3:0] row, logic [3:0] col);
    int unsigned r;
    int unsigned c;
    r = row;
    c = col;
    return cell_index_t'(r * 9 + c);
  endfunction

  // shifted-row pattern, a valid grid
  function automatic logic [3:0] solution_digit(logic [3:0] row, logic [3:0] col);
    int unsigned r;
    int unsigned c;
    r = row;
    c = col;
    return 4'((r * 3 + r / 3 + c) % 9 + 1);
  endfunction

  // easy blanks every third cell, hard blanks the odd checkerboard squares
  function automatic logic is_blank(difficulty_t diff, logic [3:0] row, logic [3:0] col);
    int unsigned idx;
    idx = cell_index(row, col);
    if (diff == diff_easy) begin
      return (idx % 3) == 0;
    end
    return (row[0] ^ col[0]) == 1'b1;
  endfunction

endpackage
